// ==== design/pm_config.svh ====
// Build-time sizing; PM_NUM_IRQ must stay within 1..32 and the counters wrap at 2**PM_CNT_W
`ifndef PM_CONFIG_SVH
`define PM_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Interrupt sizing
//////////////////////////////////////////////////////////////////////

// Number of interrupt lines seen by the wake controller
// Any value from 1 to 32 is supported
`define PM_NUM_IRQ 8

//////////////////////////////////////////////////////////////////////
// Statistics sizing
//////////////////////////////////////////////////////////////////////

// Width of both sleep statistics counters
// Software must read often enough to account for wrap-around
`define PM_CNT_W 16

`endif

// ==== design/pm_pkg.sv ====
// Shared types; all widths come from pm_config.svh, so recompile everything after changing it
`default_nettype none

`include "pm_config.svh"

package pm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Interrupt vectors
  //////////////////////////////////////////////////////////////////////

  // One bit per interrupt line, used for strobes, mask, ack and pending
  typedef logic [`PM_NUM_IRQ-1:0] irq_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Core side
  //////////////////////////////////////////////////////////////////////

  // Busy flags reported by the pipeline units
  typedef struct packed {
    logic if_busy;    // Instruction fetch still filling its buffer
    logic ctrl_busy;  // Controller not yet settled into idle
    logic lsu_busy;   // Outstanding data transaction
    logic apu_busy;   // Auxiliary unit still computing
  } core_status_t;

  // Status returned to the core controller and to the system
  typedef struct packed {
    logic fetch_enable;  // Sticky copy of the first fetch enable strobe
    logic clock_en;      // Enable for the core clock gate
    logic core_sleep;    // Core is idle with its clock gated
  } pm_status_t;

  //////////////////////////////////////////////////////////////////////
  // Statistics
  //////////////////////////////////////////////////////////////////////

  // Power accounting counters, both wrap on overflow
  typedef struct packed {
    logic [`PM_CNT_W-1:0] sleep_entries;
    logic [`PM_CNT_W-1:0] sleep_cycles;
  } pm_stats_t;

endpackage

`default_nettype wire

// ==== design/irq_wake_ctrl.sv ====
// Strobe inputs only; a new irq strobe beats an ack on the same line, and wake is combinational
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module irq_wake_ctrl
  import pm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  irq_vec_t irq_i,          // Single-cycle interrupt strobes
  input  irq_vec_t irq_mask_i,     // Level, 1 enables the line
  input  irq_vec_t irq_ack_i,      // Single-cycle acknowledge strobes
  output irq_vec_t irq_pending_o,  // Captured interrupts, masked or not
  output logic     wake_o          // Some enabled interrupt is pending
);

  irq_vec_t pending_q;
  irq_vec_t pending_d;
  irq_vec_t pending_masked;

  //////////////////////////////////////////////////////////////////////
  // Pending register
  //////////////////////////////////////////////////////////////////////

  // Each line is handled on its own
  // A strobe sets the bit, an ack clears it, and the strobe has priority
  // so an interrupt arriving in the ack cycle is never lost
  always_comb begin
    pending_d = pending_q;
    for (int i = 0; i < `PM_NUM_IRQ; i++) begin
      if (irq_i[i]) begin
        pending_d[i] = 1'b1;
      end else if (irq_ack_i[i]) begin
        pending_d[i] = 1'b0;
      end
    end
  end

  // Pending bits are control state and start clear
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wake request
  //////////////////////////////////////////////////////////////////////

  // The mask is applied after the register, not before it
  // Enabling a line that is already pending therefore wakes the core
  // in the same cycle as the mask change
  assign pending_masked = pending_q & irq_mask_i;

  // Reduce to one request; it follows an unmasked strobe by one cycle
  assign wake_o = |pending_masked;

  // Software reads this to find the line it has to acknowledge
  assign irq_pending_o = pending_q;

endmodule

`default_nettype wire

// ==== design/sleep_unit.sv ====
// No clock before the first fetch_enable_i strobe; busy flags are seen one cycle late
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module sleep_unit
  import pm_pkg::*;
(
  input  logic         clk_i,           // Free running clock
  input  logic         rst_n,
  input  logic         fetch_enable_i,  // Strobe, only the first one matters
  input  core_status_t core_status_i,   // Busy flags from the pipeline
  input  logic         wake_i,          // Enabled interrupt pending
  output logic         clock_en_o,      // To the core clock gate
  output pm_status_t   status_o
);

  logic fetch_enable_q;  // Sticky fetch enable
  logic fetch_enable_d;
  logic core_busy_q;     // Some unit still needs a clock
  logic core_busy_d;
  logic clock_en;
  logic core_sleep;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  // Once set, fetch enable stays set until reset
  assign fetch_enable_d = fetch_enable_i | fetch_enable_q;

  // Any busy unit keeps the core awake
  // Typically the fetch unit is the last one to finish
  assign core_busy_d = core_status_i.if_busy  |
                       core_status_i.ctrl_busy |
                       core_status_i.lsu_busy  |
                       core_status_i.apu_busy;

  // Both registers run on the free clock so they still see inputs
  // while the core clock is gated
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_d;
      core_busy_q    <= core_busy_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Clock enable and sleep decision
  //////////////////////////////////////////////////////////////////////

  // Clock runs after the first fetch enable while busy or while waking
  // Wake is taken directly so an interrupt reopens the gate at once
  assign clock_en = fetch_enable_q & (wake_i | core_busy_q);

  // Sleep means fetch has been allowed but the clock is off
  // Before the first fetch enable the core is gated but not asleep
  assign core_sleep = fetch_enable_q & ~clock_en;

  assign clock_en_o = clock_en;

  // Status bundle for the controller and the system
  assign status_o.fetch_enable = fetch_enable_q;
  assign status_o.clock_en     = clock_en;
  assign status_o.core_sleep   = core_sleep;

endmodule

`default_nettype wire

// ==== design/clock_gate.sv ====
// Behavioural latch gate; swap for the library ICG cell in a real flow, clk_o low while disabled
`timescale 1ns/1ps
`default_nettype none

module clock_gate (
  input  logic clk_i,         // Free running clock
  input  logic en_i,          // Functional enable
  input  logic scan_cg_en_i,  // Test mode, forces the gate open
  output logic clk_o          // Gated clock
);

  logic en_latched;

  //////////////////////////////////////////////////////////////////////
  // Enable latch
  //////////////////////////////////////////////////////////////////////

  // Transparent while the clock is low, so the enable is frozen for the
  // whole high phase and clk_o cannot be cut short or glitch
  always_latch begin
    if (!clk_i) begin
      en_latched = en_i | scan_cg_en_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output gate
  //////////////////////////////////////////////////////////////////////

  // clk_o rises only on clk_i edges where the latched enable is set
  assign clk_o = clk_i & en_latched;

endmodule

`default_nettype wire

// ==== design/sleep_stats.sv ====
// Counts on the free clock; both counters wrap silently and clear only on reset
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module sleep_stats
  import pm_pkg::*;
(
  input  logic      clk_i,         // Free running clock, not the gated one
  input  logic      rst_n,
  input  logic      core_sleep_i,  // Sleep indication from the sleep unit
  output pm_stats_t stats_o
);

  logic                 core_sleep_q;  // Sleep state at the previous edge
  logic                 sleep_rise;
  logic [`PM_CNT_W-1:0] entries_q;
  logic [`PM_CNT_W-1:0] cycles_q;

  //////////////////////////////////////////////////////////////////////
  // Entry detection
  //////////////////////////////////////////////////////////////////////

  // A rising edge of core sleep marks one entry into sleep
  assign sleep_rise = core_sleep_i & ~core_sleep_q;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Both counters are sampled at the edge that ends the sleep cycle
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      core_sleep_q <= 1'b0;
      entries_q    <= '0;
      cycles_q     <= '0;
    end else begin
      core_sleep_q <= core_sleep_i;
      if (sleep_rise) begin
        entries_q <= entries_q + `PM_CNT_W'(1);
      end
      // Every edge spent asleep adds one cycle
      if (core_sleep_i) begin
        cycles_q <= cycles_q + `PM_CNT_W'(1);
      end
    end
  end

  assign stats_o.sleep_entries = entries_q;
  assign stats_o.sleep_cycles  = cycles_q;

endmodule

`default_nettype wire

// ==== design/pm_top.sv ====
// Wiring only; irq, ack and fetch enable are single-cycle strobes with no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_top
  import pm_pkg::*;
(
  input  logic         clk_i,           // Free running clock
  input  logic         rst_n,
  input  logic         scan_cg_en_i,    // Forces the core clock on in test
  input  logic         fetch_enable_i,
  input  core_status_t core_status_i,
  input  irq_vec_t     irq_i,
  input  irq_vec_t     irq_mask_i,
  input  irq_vec_t     irq_ack_i,
  output logic         clk_o,           // Gated core clock
  output irq_vec_t     irq_pending_o,
  output pm_status_t   status_o,
  output pm_stats_t    stats_o
);

  logic       wake;
  logic       clock_en;
  pm_status_t status;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  irq_wake_ctrl u_irq_wake_ctrl (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .irq_i         (irq_i),
    .irq_mask_i    (irq_mask_i),
    .irq_ack_i     (irq_ack_i),
    .irq_pending_o (irq_pending_o),
    .wake_o        (wake)
  );

  //////////////////////////////////////////////////////////////////////
  // Sleep decision and core clock
  //////////////////////////////////////////////////////////////////////

  sleep_unit u_sleep_unit (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .core_status_i  (core_status_i),
    .wake_i         (wake),
    .clock_en_o     (clock_en),
    .status_o       (status)
  );

  // Main gate for everything on the core side
  clock_gate u_clock_gate (
    .clk_i        (clk_i),
    .en_i         (clock_en),
    .scan_cg_en_i (scan_cg_en_i),
    .clk_o        (clk_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Power accounting
  //////////////////////////////////////////////////////////////////////

  sleep_stats u_sleep_stats (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .core_sleep_i (status.core_sleep),
    .stats_o      (stats_o)
  );

  assign status_o = status;

endmodule

`default_nettype wire

// ==== verification/pm_assertions.sv ====
// Bound into sleep_unit; rules are checked on the free clock and are inactive during reset
`timescale 1ns/1ps
`default_nettype none

module pm_assertions
  import pm_pkg::*;
(
  input logic         clk_i,           // Free running clock of the sleep unit
  input logic         rst_n,
  input logic         fetch_enable_i,  // Fetch enable strobe into the unit
  input core_status_t core_status_i,   // Busy flags into the unit
  input logic         wake_i,          // Wake request into the unit
  input logic         clock_en_i,      // Enable sent to the clock gate
  input pm_status_t   status_i         // Status bundle driven by the unit
);

  //////////////////////////////////////////////////////////////////////
  // Clock enable rules
  //////////////////////////////////////////////////////////////////////

  // The core must not see a clock before a fetch enable strobe was taken
  a_no_clock_before_fetch : assert property (@(posedge clk_i) disable iff (!rst_n)
    !$past(fetch_enable_i) && !$past(status_i.fetch_enable) |-> !clock_en_i)
    else $error("clock enable is set although no fetch enable strobe was taken");

  //////////////////////////////////////////////////////////////////////
  // Sleep rules
  //////////////////////////////////////////////////////////////////////

  // A sleeping core keeps its clock gated until a unit is busy or a wake request arrives
  a_sleep_gates_clock : assert property (@(posedge clk_i) disable iff (!rst_n)
    $past(status_i.core_sleep) && !$past(|core_status_i) && !wake_i
      |-> status_i.core_sleep && !clock_en_i)
    else $error("the core left sleep or got a clock with no busy flag and no wake request");

  // Sleep is only entered once no busy flag was set at the previous edge
  a_sleep_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n)
    status_i.core_sleep |-> !$past(|core_status_i))
    else $error("core sleep is set although a busy flag was set one cycle earlier");

endmodule

// Attach the checker to every sleep unit in the design
bind sleep_unit pm_assertions u_pm_assertions (
  .clk_i          (clk_i),
  .rst_n          (rst_n),
  .fetch_enable_i (fetch_enable_i),
  .core_status_i  (core_status_i),
  .wake_i         (wake_i),
  .clock_en_i     (clock_en_o),
  .status_i       (status_o)
);

`default_nettype wire

// ==== verification/pm_tb.sv ====
// Reads verification/pm_trace.txt from the project root; trace line count is fixed by NUM_LINES
`timescale 1ns/1ps
`default_nettype none

`include "pm_config.svh"

module pm_tb
  import pm_pkg::*;
();

  localparam int NUM_LINES  = 26;
  localparam int FIELDS     = 10;
  localparam int TIMEOUT_NS = 5000;
  localparam int CLK_O_WAIT = 5;

  logic         clk_i;
  logic         rst_n;
  logic         scan_cg_en;
  logic         fetch_enable;
  core_status_t core_status;
  irq_vec_t     irq;
  irq_vec_t     irq_mask;
  irq_vec_t     irq_ack;
  logic         clk_o;
  irq_vec_t     irq_pending;
  pm_status_t   status;
  pm_stats_t    stats;

  logic [31:0]          trace_mem [0:NUM_LINES*FIELDS-1];
  int                   error_count;
  int                   check_count;
  logic [`PM_CNT_W-1:0] tally_entries;  // Sleep rises seen in the expected trace
  logic [`PM_CNT_W-1:0] tally_cycles;   // Sleep cycles seen in the expected trace
  logic                 tally_prev;

  pm_top DUT (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .scan_cg_en_i   (scan_cg_en),
    .fetch_enable_i (fetch_enable),
    .core_status_i  (core_status),
    .irq_i          (irq),
    .irq_mask_i     (irq_mask),
    .irq_ack_i      (irq_ack),
    .clk_o          (clk_o),
    .irq_pending_o  (irq_pending),
    .status_o       (status),
    .stats_o        (stats)
  );

  // 10 ns free running clock
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Hard limit on the whole run
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not reach its end within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_status(input string name, input pm_status_t exp, input pm_status_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_pending(input string name, input irq_vec_t exp, input irq_vec_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_stats(input string name, input pm_stats_t exp, input pm_stats_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace handling
  //////////////////////////////////////////////////////////////////////

  // Inputs of one trace line; a line with only if_busy set gets random
  // extra flags so the busy reduction sees mixed patterns
  task automatic drive_line(input int line);
    int          base;
    logic [3:0]  busy_bits;
    logic [31:0] fill;
    base = line * FIELDS;
    busy_bits = trace_mem[base + 1][3:0];
    if (busy_bits == 4'h8) begin
      fill = $urandom();
      busy_bits = busy_bits | {1'b0, fill[2:0]};
    end
    fetch_enable = trace_mem[base][0];
    core_status  = busy_bits;
    irq          = trace_mem[base + 2][`PM_NUM_IRQ-1:0];
    irq_mask     = trace_mem[base + 3][`PM_NUM_IRQ-1:0];
    irq_ack      = trace_mem[base + 4][`PM_NUM_IRQ-1:0];
    scan_cg_en   = trace_mem[base + 5][0];
  endtask

  // Expected outputs of one trace line, plus the running sleep tally
  task automatic check_line(input int line);
    int         base;
    pm_status_t exp_status;
    pm_stats_t  exp_stats;
    base = line * FIELDS;
    exp_status = trace_mem[base + 6][2:0];
    exp_stats.sleep_entries = trace_mem[base + 8][`PM_CNT_W-1:0];
    exp_stats.sleep_cycles  = trace_mem[base + 9][`PM_CNT_W-1:0];
    check_status($sformatf("line %0d status", line), exp_status, status);
    check_pending($sformatf("line %0d pending", line),
                  trace_mem[base + 7][`PM_NUM_IRQ-1:0], irq_pending);
    check_stats($sformatf("line %0d counters", line), exp_stats, stats);
    if (exp_status.core_sleep) begin
      tally_cycles = tally_cycles + `PM_CNT_W'(1);
      if (!tally_prev) tally_entries = tally_entries + `PM_CNT_W'(1);
    end
    tally_prev = exp_status.core_sleep;
  endtask

  // Samples the gated clock just after each free clock edge
  task automatic wait_clk_o_rise(input int max_cycles, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < max_cycles) begin
      @(posedge clk_i);
      #1;
      if (clk_o) seen = 1'b1;
      n++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    bit        seen;
    bit        trace_bad;
    pm_stats_t tally_stats;
    void'($urandom(32));
    error_count = 0;
    check_count = 0;
    tally_entries = '0;
    tally_cycles = '0;
    tally_prev = 1'b0;
    trace_bad = 1'b0;
    rst_n = 1'b0;
    scan_cg_en = 1'b0;
    fetch_enable = 1'b0;
    core_status = '0;
    irq = '0;
    irq_mask = '0;
    irq_ack = '0;
    // Marker words keep a missing or short trace from passing silently
    for (int a = 0; a < NUM_LINES * FIELDS; a++) trace_mem[a] = 32'hbad0_0000 | 32'(a);
    $readmemh("verification/pm_trace.txt", trace_mem);
    for (int a = 0; a < NUM_LINES * FIELDS; a++) begin
      if (trace_mem[a][31:16] != 16'h0) trace_bad = 1'b1;
    end
    if (trace_bad) begin
      error_count++;
      $display("The trace file is missing or holds fewer entries than expected");
    end
    repeat (4) @(posedge clk_i);
    #1 rst_n = 1'b1;
    for (int line = 0; line < NUM_LINES; line++) begin
      @(posedge clk_i);
      #1;
      drive_line(line);
      #7;
      check_line(line);
    end
    // Counters take the last trace cycle at the following edge
    @(posedge clk_i);
    #1;
    tally_stats.sleep_entries = tally_entries;
    tally_stats.sleep_cycles  = tally_cycles;
    check_stats("sleep tally", tally_stats, stats);
    // Core is asleep here, so only scan mode may open the gate
    scan_cg_en = 1'b1;
    wait_clk_o_rise(CLK_O_WAIT, seen);
    if (!seen) begin
      error_count++;
      $display("The gated clock did not toggle with scan enable set while asleep");
    end
    scan_cg_en = 1'b0;
    wait_clk_o_rise(CLK_O_WAIT, seen);
    if (seen) begin
      error_count++;
      $display("The gated clock toggled while asleep with scan enable clear");
    end
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/pm_trace.txt ====
// fetch busy(if,ctrl,lsu,apu) irq mask ack scan status(fetch,clock_en,sleep) pending entries cycles
// Outputs are those seen late in the same cycle; counters hold the edges already taken
0 f 00 00 00 0 0 00 0000 0000
1 8 00 00 00 0 0 00 0000 0000
0 8 00 00 00 0 6 00 0000 0000
0 4 00 00 00 0 6 00 0000 0000
0 2 00 00 00 0 6 00 0000 0000
0 1 00 00 00 0 6 00 0000 0000
0 0 00 00 00 0 6 00 0000 0000
0 0 00 00 00 0 5 00 0000 0000
0 0 04 00 00 0 5 00 0001 0001
0 0 00 00 00 0 5 04 0001 0002
0 0 00 04 00 0 6 04 0001 0003
0 0 00 04 04 0 6 04 0001 0003
0 0 00 04 00 0 5 00 0001 0003
0 0 01 ff 00 0 5 00 0002 0004
0 0 00 ff 00 0 6 01 0002 0005
0 0 01 ff 01 0 6 01 0002 0005
0 0 00 ff 00 0 6 01 0002 0005
0 0 00 ff 01 0 6 01 0002 0005
0 0 00 ff 00 0 5 00 0002 0005
0 2 00 ff 00 0 5 00 0003 0006
0 0 00 ff 00 0 6 00 0003 0007
0 0 00 ff 00 0 5 00 0003 0007
0 0 00 ff 00 1 5 00 0004 0008
0 0 00 ff 00 0 5 00 0004 0009
1 0 00 ff 00 0 5 00 0004 000a
0 0 00 ff 00 0 5 00 0004 000b

// ==== list.f ====
+incdir+design
design/pm_pkg.sv
design/irq_wake_ctrl.sv
design/sleep_unit.sv
design/clock_gate.sv
design/sleep_stats.sv
design/pm_top.sv
verification/pm_assertions.sv
verification/pm_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the power-management testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module pm_tb -Mdir obj_dir -o pm_sim

./obj_dir/pm_sim | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "No errors" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
